// File: rtl/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data path
`define RV_XLEN 32
`define RV_REG_ADDR_W 5

// Instruction queue entries, and the credits the producer starts with
`define RV_IQ_DEPTH 4

// Result credits held by the core after reset
`define RV_RES_CREDITS 2

// Wide enough for the larger of the two credit pools
`define RV_CREDIT_CNT_W 3

`endif

// File: rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [6:0] funct7_t;

    // Major opcodes handled by this core
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // ALU function codes, shared by OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    localparam funct7_t F7_ZERO = 7'b0000000;
    // SUB and SRA/SRAI
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

// File: rtl/rv_ctrl_pkg.sv
`default_nettype none

`include "rv_defines.svh"

package rv_ctrl_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_idx_t;

    // Low eight codes line up with funct3
    typedef enum logic [3:0] {
        ALU_ADD_SUB = 4'd0,
        ALU_SLL     = 4'd1,
        ALU_SLT     = 4'd2,
        ALU_SLTU    = 4'd3,
        ALU_XOR     = 4'd4,
        ALU_SRL_SRA = 4'd5,
        ALU_OR      = 4'd6,
        ALU_AND     = 4'd7,
        ALU_SRC2    = 4'd8
    } alu_op_e;

    typedef enum logic {
        SRC1_REG = 1'b0,
        SRC1_PC  = 1'b1
    } alu_src1_e;

    typedef enum logic {
        SRC2_REG = 1'b0,
        SRC2_IMM = 1'b1
    } alu_src2_e;

endpackage

`default_nettype wire

// File: rtl/rv_instr_fifo.sv
`default_nettype none

`include "rv_defines.svh"

module rv_instr_fifo (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                push_i,
    input  rv_isa_pkg::instr_t  instr_i,
    input  rv_ctrl_pkg::word_t  pc_i,
    input  logic                pop_i,
    output logic                valid_o,
    output rv_isa_pkg::instr_t  instr_o,
    output rv_ctrl_pkg::word_t  pc_o,
    output logic                credit_o
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam int PTR_W = $clog2(`RV_IQ_DEPTH);

    instr_t instr_mem [`RV_IQ_DEPTH];
    word_t pc_mem [`RV_IQ_DEPTH];

    // Depth is a power of two, pointers wrap on their own
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [`RV_CREDIT_CNT_W-1:0] count;
    logic do_pop;

    assign valid_o = count != '0;
    assign do_pop = pop_i && valid_o;
    assign instr_o = instr_mem[rd_ptr];
    assign pc_o = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            if (push_i && !do_pop) count <= count + 1'b1;
            else if (!push_i && do_pop) count <= count - 1'b1;
            // One credit back to the producer per freed entry
            credit_o <= do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push_i) begin
            instr_mem[wr_ptr] <= instr_i;
            pc_mem[wr_ptr] <= pc_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_regfile.sv
`default_nettype none

`include "rv_defines.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset_i,
    input  rv_ctrl_pkg::reg_idx_t rs1_i,
    input  rv_ctrl_pkg::reg_idx_t rs2_i,
    input  logic                  we_i,
    input  rv_ctrl_pkg::reg_idx_t rd_i,
    input  rv_ctrl_pkg::word_t    rd_value_i,
    output rv_ctrl_pkg::word_t    rs1_value_o,
    output rv_ctrl_pkg::word_t    rs2_value_o
);
    import rv_ctrl_pkg::*;

    localparam int NUM_REGS = 2 ** `RV_REG_ADDR_W;

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= rd_value_i;
        end
    end

    // Same-cycle write is not bypassed here
    assign rs1_value_o = (rs1_i == '0) ? '0 : regs[rs1_i];
    assign rs2_value_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: rtl/rv_decode.sv
`default_nettype none

module rv_decode (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   advance_i,
    input  logic                   head_valid_i,
    input  rv_isa_pkg::instr_t     instr_i,
    input  rv_ctrl_pkg::word_t     pc_i,
    input  rv_ctrl_pkg::word_t     rs1_value_i,
    input  rv_ctrl_pkg::word_t     rs2_value_i,
    output rv_ctrl_pkg::reg_idx_t  rs1_idx_o,
    output rv_ctrl_pkg::reg_idx_t  rs2_idx_o,
    output logic                   valid_o,
    output rv_ctrl_pkg::alu_op_e   alu_op_o,
    output logic                   alu_sub_sra_o,
    output rv_ctrl_pkg::alu_src1_e alu_src1_o,
    output rv_ctrl_pkg::alu_src2_e alu_src2_o,
    output rv_ctrl_pkg::word_t     pc_o,
    output rv_ctrl_pkg::word_t     imm_o,
    output rv_ctrl_pkg::word_t     rs1_value_o,
    output rv_ctrl_pkg::word_t     rs2_value_o,
    output rv_ctrl_pkg::reg_idx_t  rd_o
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    opcode_e opcode;
    funct3_e funct3;
    funct7_t funct7;
    word_t imm_itype;
    word_t imm_utype;
    word_t imm_shamt;
    logic is_alt;
    logic is_cmp;

    logic dec_match;
    alu_op_e dec_op;
    logic dec_sub;
    alu_src1_e dec_src1;
    alu_src2_e dec_src2;
    word_t dec_imm;

    assign opcode = opcode_e'(instr_i[6:0]);
    assign funct3 = funct3_e'(instr_i[14:12]);
    assign funct7 = instr_i[31:25];
    assign is_alt = funct7 == F7_ALT;
    assign is_cmp = funct3 == F3_SLT || funct3 == F3_SLTU;

    assign imm_itype = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_utype = {instr_i[31:12], 12'b0};
    assign imm_shamt = {27'b0, instr_i[24:20]};

    // ********************
    // Control decode
    always_comb begin
        dec_match = 1'b0;
        dec_op = alu_op_e'({1'b0, funct3});
        dec_sub = 1'b0;
        dec_src1 = SRC1_REG;
        dec_src2 = SRC2_IMM;
        dec_imm = imm_itype;
        case (opcode)
            OPC_LUI: begin
                dec_match = 1'b1;
                dec_op = ALU_SRC2;
                dec_imm = imm_utype;
            end
            OPC_AUIPC: begin
                dec_match = 1'b1;
                dec_op = ALU_ADD_SUB;
                dec_src1 = SRC1_PC;
                dec_imm = imm_utype;
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_SLL: begin
                        dec_match = funct7 == F7_ZERO;
                        dec_imm = imm_shamt;
                    end
                    F3_SRL_SRA: begin
                        dec_match = funct7 == F7_ZERO || is_alt;
                        dec_sub = is_alt;
                        dec_imm = imm_shamt;
                    end
                    default: begin
                        dec_match = 1'b1;
                        dec_sub = is_cmp;
                    end
                endcase
            end
            OPC_OP: begin
                // funct7 may only flip ADD/SUB and SRL/SRA
                dec_match = funct7 == F7_ZERO ||
                            (is_alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
                dec_sub = is_alt || is_cmp;
                dec_src2 = SRC2_REG;
            end
            default: dec_match = 1'b0;
        endcase
    end

    // ********************
    // Decode pipeline register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= head_valid_i && dec_match;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            rs1_idx_o <= instr_i[19:15];
            rs2_idx_o <= instr_i[24:20];
            rd_o <= instr_i[11:7];
            alu_op_o <= dec_op;
            alu_sub_sra_o <= dec_sub;
            alu_src1_o <= dec_src1;
            alu_src2_o <= dec_src2;
            pc_o <= pc_i;
            imm_o <= dec_imm;
            rs1_value_o <= rs1_value_i;
            rs2_value_o <= rs2_value_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_execute.sv
`default_nettype none

`include "rv_defines.svh"

module rv_execute (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   advance_i,
    input  logic                   valid_i,
    input  rv_ctrl_pkg::alu_op_e   alu_op_i,
    input  logic                   alu_sub_sra_i,
    input  rv_ctrl_pkg::alu_src1_e alu_src1_i,
    input  rv_ctrl_pkg::alu_src2_e alu_src2_i,
    input  rv_ctrl_pkg::reg_idx_t  rs1_idx_i,
    input  rv_ctrl_pkg::reg_idx_t  rs2_idx_i,
    input  rv_ctrl_pkg::word_t     pc_i,
    input  rv_ctrl_pkg::word_t     imm_i,
    input  rv_ctrl_pkg::word_t     rs1_value_i,
    input  rv_ctrl_pkg::word_t     rs2_value_i,
    input  rv_ctrl_pkg::reg_idx_t  rd_i,
    input  logic                   res_valid_i,
    input  rv_ctrl_pkg::reg_idx_t  res_rd_i,
    input  rv_ctrl_pkg::word_t     res_value_i,
    output logic                   valid_o,
    output rv_ctrl_pkg::reg_idx_t  rd_o,
    output rv_ctrl_pkg::word_t     value_o
);
    import rv_ctrl_pkg::*;

    localparam int MSB = `RV_XLEN - 1;

    logic res_fwd_q;
    word_t fwd1;
    word_t fwd2;
    word_t op_a;
    word_t op_b;
    logic [`RV_XLEN:0] sum;
    logic lt_signed;
    logic lt_unsigned;
    word_t alu_value;

    // ********************
    // Forwarding
    // The result register holds a write the decoded operands missed only if it
    // was captured on the edge that loaded them
    always_ff @(posedge clk) begin
        if (reset_i) begin
            res_fwd_q <= 1'b0;
        end else if (advance_i) begin
            res_fwd_q <= res_valid_i;
        end
    end

    // Youngest producer wins
    assign fwd1 = (valid_o && rd_o != '0 && rd_o == rs1_idx_i) ? value_o :
                  (res_fwd_q && res_rd_i != '0 && res_rd_i == rs1_idx_i) ? res_value_i :
                  rs1_value_i;
    assign fwd2 = (valid_o && rd_o != '0 && rd_o == rs2_idx_i) ? value_o :
                  (res_fwd_q && res_rd_i != '0 && res_rd_i == rs2_idx_i) ? res_value_i :
                  rs2_value_i;

    assign op_a = (alu_src1_i == SRC1_PC) ? pc_i : fwd1;
    assign op_b = (alu_src2_i == SRC2_IMM) ? imm_i : fwd2;

    // ********************
    // ALU
    // Compares reuse the subtractor
    assign sum = {1'b0, op_a} + {1'b0, op_b ^ {`RV_XLEN{alu_sub_sra_i}}} + alu_sub_sra_i;
    assign lt_unsigned = !sum[`RV_XLEN];
    assign lt_signed = (op_a[MSB] != op_b[MSB]) ? op_a[MSB] : sum[MSB];

    always_comb begin
        case (alu_op_i)
            ALU_ADD_SUB: alu_value = sum[MSB:0];
            ALU_SLL:     alu_value = op_a << op_b[4:0];
            ALU_SLT:     alu_value = word_t'(lt_signed);
            ALU_SLTU:    alu_value = word_t'(lt_unsigned);
            ALU_XOR:     alu_value = op_a ^ op_b;
            ALU_SRL_SRA: alu_value = word_t'($signed({alu_sub_sra_i && op_a[MSB], op_a})
                                              >>> op_b[4:0]);
            ALU_OR:      alu_value = op_a | op_b;
            ALU_AND:     alu_value = op_a & op_b;
            ALU_SRC2:    alu_value = op_b;
            default:     alu_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o <= 1'b0;
        end else if (advance_i) begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_i) begin
            rd_o <= rd_i;
            value_o <= alu_value;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_result.sv
`default_nettype none

`include "rv_defines.svh"

module rv_result (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  valid_i,
    input  rv_ctrl_pkg::reg_idx_t rd_i,
    input  rv_ctrl_pkg::word_t    value_i,
    input  logic                  result_credit_i,
    output logic                  advance_o,
    output logic                  we_o,
    output logic                  result_valid_o,
    output rv_ctrl_pkg::reg_idx_t result_rd_o,
    output rv_ctrl_pkg::word_t    result_value_o
);
    logic [`RV_CREDIT_CNT_W-1:0] credits;

    // Whole pipeline stalls once the consumer is out of room
    assign advance_o = credits != '0;
    assign we_o = advance_o && valid_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            credits <= `RV_RES_CREDITS;
            result_valid_o <= 1'b0;
        end else begin
            credits <= credits - we_o + result_credit_i;
            result_valid_o <= we_o;
        end
    end

    always_ff @(posedge clk) begin
        if (we_o) begin
            result_rd_o <= rd_i;
            result_value_o <= value_i;
        end
    end

endmodule

`default_nettype wire

// File: rtl/rv_core.sv
`default_nettype none

module rv_core (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  instr_valid_i,
    input  rv_isa_pkg::instr_t    instr_i,
    input  rv_ctrl_pkg::word_t    pc_i,
    input  logic                  result_credit_i,
    output logic                  instr_credit_o,
    output logic                  result_valid_o,
    output rv_ctrl_pkg::reg_idx_t result_rd_o,
    output rv_ctrl_pkg::word_t    result_value_o
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic advance;
    logic we;

    logic iq_valid;
    instr_t iq_instr;
    word_t iq_pc;

    word_t rf_rs1_value;
    word_t rf_rs2_value;

    logic de_valid;
    alu_op_e de_alu_op;
    logic de_sub_sra;
    alu_src1_e de_src1;
    alu_src2_e de_src2;
    reg_idx_t de_rs1_idx;
    reg_idx_t de_rs2_idx;
    reg_idx_t de_rd;
    word_t de_pc;
    word_t de_imm;
    word_t de_rs1_value;
    word_t de_rs2_value;

    logic ex_valid;
    reg_idx_t ex_rd;
    word_t ex_value;

    rv_instr_fifo instr_fifo_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .push_i   (instr_valid_i),
        .instr_i  (instr_i),
        .pc_i     (pc_i),
        .pop_i    (advance),
        .valid_o  (iq_valid),
        .instr_o  (iq_instr),
        .pc_o     (iq_pc),
        .credit_o (instr_credit_o)
    );

    // Register file is addressed straight from the queue head
    rv_regfile regfile_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .rs1_i       (iq_instr[19:15]),
        .rs2_i       (iq_instr[24:20]),
        .we_i        (we),
        .rd_i        (ex_rd),
        .rd_value_i  (ex_value),
        .rs1_value_o (rf_rs1_value),
        .rs2_value_o (rf_rs2_value)
    );

    rv_decode decode_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .advance_i     (advance),
        .head_valid_i  (iq_valid),
        .instr_i       (iq_instr),
        .pc_i          (iq_pc),
        .rs1_value_i   (rf_rs1_value),
        .rs2_value_i   (rf_rs2_value),
        .rs1_idx_o     (de_rs1_idx),
        .rs2_idx_o     (de_rs2_idx),
        .valid_o       (de_valid),
        .alu_op_o      (de_alu_op),
        .alu_sub_sra_o (de_sub_sra),
        .alu_src1_o    (de_src1),
        .alu_src2_o    (de_src2),
        .pc_o          (de_pc),
        .imm_o         (de_imm),
        .rs1_value_o   (de_rs1_value),
        .rs2_value_o   (de_rs2_value),
        .rd_o          (de_rd)
    );

    rv_execute execute_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .advance_i     (advance),
        .valid_i       (de_valid),
        .alu_op_i      (de_alu_op),
        .alu_sub_sra_i (de_sub_sra),
        .alu_src1_i    (de_src1),
        .alu_src2_i    (de_src2),
        .rs1_idx_i     (de_rs1_idx),
        .rs2_idx_i     (de_rs2_idx),
        .pc_i          (de_pc),
        .imm_i         (de_imm),
        .rs1_value_i   (de_rs1_value),
        .rs2_value_i   (de_rs2_value),
        .rd_i          (de_rd),
        .res_valid_i   (we),
        .res_rd_i      (result_rd_o),
        .res_value_i   (result_value_o),
        .valid_o       (ex_valid),
        .rd_o          (ex_rd),
        .value_o       (ex_value)
    );

    rv_result result_inst (
        .clk             (clk),
        .reset_i         (reset_i),
        .valid_i         (ex_valid),
        .rd_i            (ex_rd),
        .value_i         (ex_value),
        .result_credit_i (result_credit_i),
        .advance_o       (advance),
        .we_o            (we),
        .result_valid_o  (result_valid_o),
        .result_rd_o     (result_rd_o),
        .result_value_o  (result_value_o)
    );

endmodule

`default_nettype wire

// File: dv/rv_core_tb.sv
`default_nettype none

`include "rv_defines.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
    localparam logic [6:0] OPCODE_AUIPC  = 7'b0010111;

    localparam int UPPER_ITER = 8;
    localparam int RAND_ITER = 6;
    localparam int CHAIN_LEN = 24;
    localparam int X0_INSTR = 4;
    localparam int UNSUP_INSTR = 6;
    localparam int BP_BURST = 7;
    localparam int SLOW_ITER = 16;
    localparam int TOTAL_INSTR = 2 * UPPER_ITER + RAND_ITER * 8 + 98 + RAND_ITER * 14
                                 + CHAIN_LEN + X0_INSTR + UNSUP_INSTR + BP_BURST + SLOW_ITER;
    localparam int CYCLE_LIMIT = 40 * TOTAL_INSTR;
    // Queue full plus three stages still in flight
    localparam int DRAIN_LIMIT = 40 * (`RV_IQ_DEPTH + 3);

    logic clk;
    logic reset;
    logic instr_valid;
    instr_t instr;
    word_t pc;
    logic result_credit;
    logic instr_credit;
    logic result_valid;
    reg_idx_t result_rd;
    word_t result_value;

    word_t ref_regs [32];
    reg_idx_t exp_rd_q [$];
    word_t exp_val_q [$];
    logic [31:0] lcg_state;
    word_t pc_next;
    int iq_credits;
    int held;
    int seen;
    int returned;
    logic hold_credits;
    int credit_gap;
    int gap_cnt;

    rv_core rv_core_inst (
        .clk             (clk),
        .reset_i         (reset),
        .instr_valid_i   (instr_valid),
        .instr_i         (instr),
        .pc_i            (pc),
        .result_credit_i (result_credit),
        .instr_credit_o  (instr_credit),
        .result_valid_o  (result_valid),
        .result_rd_o     (result_rd),
        .result_value_o  (result_value)
    );

    always #50 clk = ~clk;

    // ********************
    // Reporting and checks
    task automatic fail_run();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_idx(input string name, input reg_idx_t actual,
                               input reg_idx_t expected);
        if (actual !== expected) begin
            $display("error: %s = 0x%h, expected 0x%h", name, actual, expected);
            fail_run();
        end
    endtask

    task automatic compare_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("error: %s = 0x%h, expected 0x%h", name, actual, expected);
            fail_run();
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ********************
    // Reference model
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Returns 0 for an encoding the core does not support
    function automatic logic model_exec(input instr_t ins, input word_t ipc,
                                        output reg_idx_t rd, output word_t val);
        logic [2:0] f3;
        logic [6:0] f7;
        word_t a;
        word_t b;
        logic alt;
        logic ok;
        f3 = ins[14:12];
        f7 = ins[31:25];
        rd = ins[11:7];
        a = ref_regs[ins[19:15]];
        b = {{20{ins[31]}}, ins[31:20]};
        alt = f7 == 7'h20;
        ok = 1'b0;
        val = '0;
        case (ins[6:0])
            OPCODE_LUI: begin
                ok = 1'b1;
                val = {ins[31:12], 12'b0};
            end
            OPCODE_AUIPC: begin
                ok = 1'b1;
                val = ipc + {ins[31:12], 12'b0};
            end
            OPCODE_OP_IMM: begin
                if (f3 == 3'b001) ok = f7 == 7'h00;
                else if (f3 == 3'b101) ok = f7 == 7'h00 || alt;
                else ok = 1'b1;
                val = alu_ref(f3, alt && f3 == 3'b101, a, b);
            end
            OPCODE_OP: begin
                b = ref_regs[ins[24:20]];
                ok = f7 == 7'h00 || (alt && (f3 == 3'b000 || f3 == 3'b101));
                val = alu_ref(f3, alt, a, b);
            end
            default: ok = 1'b0;
        endcase
        if (ok && rd != '0) ref_regs[rd] = val;
        return ok;
    endfunction

    function automatic instr_t enc_i(input logic [11:0] imm, input int rs1,
                                     input logic [2:0] f3, input int rd);
        return {imm, rs1[4:0], f3, rd[4:0], OPCODE_OP_IMM};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input int rd, input logic [6:0] opc);
        return {imm, rd[4:0], opc};
    endfunction

    // Operations in order ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    function automatic instr_t enc_rr(input int op, input int rs1, input int rs2, input int rd);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = (op == 1 || op == 7) ? 7'h20 : 7'h00;
        case (op)
            0, 1: f3 = 3'b000;
            2: f3 = 3'b001;
            3: f3 = 3'b010;
            4: f3 = 3'b011;
            5: f3 = 3'b100;
            6, 7: f3 = 3'b101;
            8: f3 = 3'b110;
            default: f3 = 3'b111;
        endcase
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], OPCODE_OP};
    endfunction

    // ********************
    // Per-cycle producer and consumer handling
    task automatic sample_cycle();
        reg_idx_t want_rd;
        word_t want_val;
        @(negedge clk);
        instr_valid = 1'b0;
        if (instr_credit) iq_credits++;
        if (iq_credits > `RV_IQ_DEPTH) begin
            $display("more instruction credits came back than were spent");
            fail_run();
        end
        if (result_valid) begin
            if (exp_rd_q.size() == 0) begin
                $display("a result arrived with no expected entry waiting");
                fail_run();
            end else begin
                want_rd = exp_rd_q.pop_front();
                want_val = exp_val_q.pop_front();
                compare_idx("result_rd_o", result_rd, want_rd);
                compare_word("result_value_o", result_value, want_val);
                seen++;
                held++;
            end
        end
        if (seen - returned > `RV_RES_CREDITS) begin
            $display("more results outstanding than result credits");
            fail_run();
        end
        gap_cnt++;
        result_credit = 1'b0;
        if (!hold_credits && held > 0 && gap_cnt >= credit_gap) begin
            result_credit = 1'b1;
            held--;
            returned++;
            gap_cnt = 0;
        end
    endtask

    task automatic issue_instr(input instr_t ins);
        reg_idx_t rd;
        word_t val;
        sample_cycle();
        while (iq_credits == 0) sample_cycle();
        instr_valid = 1'b1;
        instr = ins;
        pc = pc_next;
        iq_credits--;
        if (model_exec(ins, pc_next, rd, val)) begin
            exp_rd_q.push_back(rd);
            exp_val_q.push_back(val);
        end
        pc_next += 4;
    endtask

    task automatic load_reg(input int rd, input logic [31:0] value);
        logic [19:0] upper;
        upper = value[31:12] + value[11];
        issue_instr(enc_u(upper, rd, OPCODE_LUI));
        issue_instr(enc_i(value[11:0], rd, 3'b000, rd));
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        sample_cycle();
        while ((exp_rd_q.size() != 0 || iq_credits != `RV_IQ_DEPTH || held != 0)
               && waited < DRAIN_LIMIT) begin
            sample_cycle();
            waited++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("expected results never arrived");
            fail_run();
        end
        if (iq_credits != `RV_IQ_DEPTH) begin
            $display("instruction credits were not all returned");
            fail_run();
        end
        repeat (4) sample_cycle();
    endtask

    // ********************
    // Directed tests
    task automatic test_upper();
        logic [31:0] r;
        for (int i = 0; i < UPPER_ITER; i++) begin
            r = next_rand();
            issue_instr(enc_u(r[19:0], 5 + i % 3, OPCODE_LUI));
            r = next_rand();
            issue_instr(enc_u(r[31:12], 9 + i % 3, OPCODE_AUIPC));
        end
    endtask

    task automatic test_reg_imm();
        logic [31:0] r;
        for (int it = 0; it < RAND_ITER; it++) begin
            load_reg(1, next_rand());
            for (int f = 0; f < 8; f++) begin
                r = next_rand();
                if (f != 1 && f != 5) issue_instr(enc_i(r[11:0], 1, f[2:0], 5 + f));
            end
        end
        // Sign bit set so SRAI and SRLI differ
        load_reg(1, next_rand() | 32'h8000_0000);
        for (int sh = 0; sh < 32; sh++) begin
            issue_instr(enc_i({7'h00, sh[4:0]}, 1, 3'b001, 5));
            issue_instr(enc_i({7'h00, sh[4:0]}, 1, 3'b101, 6));
            issue_instr(enc_i({7'h20, sh[4:0]}, 1, 3'b101, 7));
        end
    endtask

    task automatic test_reg_reg();
        logic [31:0] r;
        int prev1;
        int prev2;
        int rd;
        for (int it = 0; it < RAND_ITER; it++) begin
            load_reg(1, next_rand());
            load_reg(2, next_rand());
            for (int op = 0; op < 10; op++) issue_instr(enc_rr(op, 1, 2, 5 + op));
        end
        // Each link reads the one before and the one two before
        prev1 = 5;
        prev2 = 6;
        for (int k = 0; k < CHAIN_LEN; k++) begin
            r = next_rand();
            rd = 10 + k % 5;
            issue_instr(enc_rr(int'(r % 10), prev1, prev2, rd));
            prev2 = prev1;
            prev1 = rd;
        end
    endtask

    task automatic test_x0();
        issue_instr(enc_i(12'h123, 1, 3'b000, 0));
        issue_instr(enc_u(20'habcde, 0, OPCODE_LUI));
        issue_instr(enc_rr(0, 0, 0, 8));
        issue_instr(enc_i(12'h7ff, 0, 3'b110, 9));
    endtask

    task automatic test_unsupported();
        issue_instr(enc_i(12'h055, 0, 3'b000, 3));
        // MUL x3, x1, x2
        issue_instr({7'h01, 5'd2, 5'd1, 3'b000, 5'd3, OPCODE_OP});
        issue_instr(enc_rr(0, 3, 0, 4));
        // LW x3, 0(x1)
        issue_instr({12'h000, 5'd1, 3'b010, 5'd3, 7'b0000011});
        issue_instr(enc_i({7'h20, 5'd3}, 1, 3'b001, 3));
        issue_instr(enc_rr(0, 3, 3, 4));
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        hold_credits = 1'b1;
        for (int i = 0; i < BP_BURST; i++) begin
            r = next_rand();
            issue_instr(enc_i(r[11:0], 0, 3'b000, 15 + i));
        end
        repeat (20) sample_cycle();
        if (held != `RV_RES_CREDITS) begin
            $display("core stopped short of its result credits while they were withheld");
            fail_run();
        end
        hold_credits = 1'b0;
        credit_gap = 3;
        for (int i = 0; i < SLOW_ITER; i++) begin
            r = next_rand();
            issue_instr(enc_rr(int'(r % 10), 15 + int'(r[7:5]), 15 + int'(r[10:8]),
                               15 + int'(r[13:11])));
        end
        drain();
        credit_gap = 1;
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, the core stopped responding", CYCLE_LIMIT);
        fail_run();
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        result_credit = 1'b0;
        lcg_state = 32'hbb6c_07a3;
        pc_next = 32'h0000_1000;
        iq_credits = `RV_IQ_DEPTH;
        held = 0;
        seen = 0;
        returned = 0;
        hold_credits = 1'b0;
        credit_gap = 1;
        gap_cnt = 0;
        for (int i = 0; i < 32; i++) ref_regs[i] = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        test_upper();
        drain();
        test_reg_imm();
        drain();
        test_reg_reg();
        drain();
        test_x0();
        drain();
        test_unsupported();
        drain();
        test_backpressure();

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_core.f
+incdir+rtl
rtl/rv_isa_pkg.sv
rtl/rv_ctrl_pkg.sv
rtl/rv_instr_fifo.sv
rtl/rv_regfile.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_result.sv
rtl/rv_core.sv
dv/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - rtl

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/rv_ctrl_pkg.sv
  - rtl/rv_instr_fifo.sv
  - rtl/rv_regfile.sv
  - rtl/rv_decode.sv
  - rtl/rv_execute.sv
  - rtl/rv_result.sv
  - rtl/rv_core.sv
  - target: test
    files:
      - dv/rv_core_tb.sv
